//--- vertex_update_top.f
gnn_pkg.sv
weight_stream_if.sv
weight_sram.sv
weight_cntl.sv
feature_streamer.sv
vertex_mac.sv
vertex_update_top.sv
tb_vertex_update.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vertex update testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vertex_update \
    -f vertex_update_top.f -o sim_vertex_update
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_vertex_update > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- tb_vertex_update.sv
module tb_vertex_update
    import gnn_pkg::*;
();

    typedef enum int {
        RAND_VAL,
        MIN_VAL,
        MAX_VAL,
        RAND_EXTREME
    } fill_t;

    logic                      clk;
    logic                      reset;
    logic                      fire;
    logic [LAYER_W-1:0]        num_layers;
    logic [FV_CNT_W-1:0]       num_fv;
    logic                      wload_en;
    logic [WADDR_W-1:0]        wload_addr;
    logic [WEIGHT_SRAM_BW-1:0] wload_data;
    logic                      fload_en;
    logic [CHUNK_W-1:0]        fload_addr;
    logic [WEIGHT_SRAM_BW-1:0] fload_data;
    logic                      busy;
    logic                      result_valid;
    logic signed [ACC_W-1:0]   result_data;
    logic [LAYER_W-1:0]        result_layer;
    logic                      result_last;

    // local copies of what was loaded
    logic signed [FV_SIZE-1:0] w_ref [SRAM_DEPTH][MULT_PER_PE];
    logic signed [FV_SIZE-1:0] f_ref [NUM_CHUNKS][MULT_PER_PE];

    longint exp_val[$];
    int     exp_layer[$];
    bit     exp_last[$];
    longint exp_cycle[$];

    logic [15:0] lfsr = 16'd17;
    longint      cycle = 0;
    bit          fired_once;
    string       cur_test;
    logic        busy_q;

    vertex_update_top vertex_update_top_inst (
        .clk          (clk),
        .reset        (reset),
        .fire         (fire),
        .num_layers   (num_layers),
        .num_fv       (num_fv),
        .wload_en     (wload_en),
        .wload_addr   (wload_addr),
        .wload_data   (wload_data),
        .fload_en     (fload_en),
        .fload_addr   (fload_addr),
        .fload_data   (fload_data),
        .busy         (busy),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_layer (result_layer),
        .result_last  (result_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hB400;
            end
            v = {v[14:0], b};
        end
        return v;
    endfunction

    function automatic logic signed [FV_SIZE-1:0] make_elem(input fill_t mode);
        case (mode)
            MIN_VAL:      return 16'sh8000;
            MAX_VAL:      return 16'sh7FFF;
            RAND_EXTREME: return (rand_bits(1) == 16'd1) ? 16'sh7FFF : 16'sh8000;
            default:      return rand_bits(16);
        endcase
    endfunction

    // signed dot product of one layer's weights with the feature vector
    function automatic longint expected_dot(input int layer, input int nfv);
        longint sum;
        int     addr;
        sum = 0;
        for (int c = 0; c < nfv / MULT_PER_PE; c++) begin
            addr = layer * NUM_CHUNKS + c;
            for (int i = 0; i < MULT_PER_PE; i++) begin
                sum += longint'(w_ref[addr][i]) * longint'(f_ref[c][i]);
            end
        end
        return sum;
    endfunction

    // all weight lines, and feature chunks alongside the first ones
    task automatic load_data(input fill_t wmode, input fill_t fmode);
        logic [WEIGHT_SRAM_BW-1:0] wline;
        logic [WEIGHT_SRAM_BW-1:0] fline;
        for (int a = 0; a < SRAM_DEPTH; a++) begin
            for (int i = 0; i < MULT_PER_PE; i++) begin
                w_ref[a][i] = make_elem(wmode);
                wline[i*FV_SIZE +: FV_SIZE] = w_ref[a][i];
            end
            wload_en   = 1'b1;
            wload_addr = WADDR_W'(a);
            wload_data = wline;
            fload_en   = 1'b0;
            if (a < NUM_CHUNKS) begin
                for (int i = 0; i < MULT_PER_PE; i++) begin
                    f_ref[a][i] = make_elem(fmode);
                    fline[i*FV_SIZE +: FV_SIZE] = f_ref[a][i];
                end
                fload_en   = 1'b1;
                fload_addr = CHUNK_W'(a);
                fload_data = fline;
            end
            next_cycle();
        end
        wload_en = 1'b0;
        fload_en = 1'b0;
    endtask

    task automatic run_layers(input string name, input int nl, input int nfv, input bit extra);
        int     c_beats;
        int     n_lay;
        int     t;
        longint fire_cyc;
        cur_test   = name;
        c_beats    = nfv / MULT_PER_PE;
        n_lay      = nl + 1;
        num_layers = LAYER_W'(nl);
        num_fv     = FV_CNT_W'(nfv);
        fire       = 1'b1;
        fired_once = 1'b1;
        // fire is taken at the next edge
        fire_cyc = cycle + 1;
        for (int j = 0; j < n_lay; j++) begin
            exp_val.push_back(expected_dot(j, nfv));
            exp_layer.push_back(j);
            exp_last.push_back(j == n_lay - 1);
            exp_cycle.push_back(fire_cyc + 3 + (j + 1) * c_beats);
        end
        next_cycle();
        fire = 1'b0;
        t = 0;
        while (!busy) begin
            if (t == 10) begin
                stop_with_error($sformatf("timeout: busy never rose after fire in %s", name));
            end
            next_cycle();
            t++;
        end
        // busy rises one cycle after the edge that takes fire
        assert (t == 1)
        else stop_with_error($sformatf("ERROR %s: busy rise cycle expected 1 actual %0d",
                                       name, t));
        t = 0;
        while (busy) begin
            if (t == 200) begin
                stop_with_error($sformatf("timeout: busy never fell in %s", name));
            end
            // extra pulses land only while busy is high
            if (extra) begin
                fire = !fire;
            end
            next_cycle();
            t++;
        end
        fire = 1'b0;
        next_cycle();
        next_cycle();
        assert (exp_val.size() == 0)
        else stop_with_error($sformatf("%s ended with %0d results missing", name, exp_val.size()));
    endtask

    task automatic check_result();
        longint exp_v;
        int     exp_l;
        bit     exp_t;
        longint exp_c;
        assert (exp_val.size() > 0)
        else stop_with_error($sformatf("unexpected result strobe in %s", cur_test));
        exp_v = exp_val.pop_front();
        exp_l = exp_layer.pop_front();
        exp_t = exp_last.pop_front();
        exp_c = exp_cycle.pop_front();
        assert (longint'(result_data) == exp_v)
        else stop_with_error($sformatf("ERROR %s: result_data expected %0d actual %0d",
                                       cur_test, exp_v, longint'(result_data)));
        assert (int'(result_layer) == exp_l)
        else stop_with_error($sformatf("ERROR %s: result_layer expected %0d actual %0d",
                                       cur_test, exp_l, result_layer));
        assert (result_last == exp_t)
        else stop_with_error($sformatf("ERROR %s: result_last expected %0d actual %0d",
                                       cur_test, exp_t, result_last));
        assert (cycle == exp_c)
        else stop_with_error($sformatf("ERROR %s: result cycle expected %0d actual %0d",
                                       cur_test, exp_c, cycle));
    endtask

    // outputs only change on rising edges, so look at them on the falling one
    initial begin
        busy_q = 1'b0;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (!fired_once) begin
                assert (!result_valid && !result_last && !busy)
                else stop_with_error("outputs were not idle during reset or before the first fire");
            end
            // busy drops on the same edge that raises result_last
            assert (result_last == (busy_q && !busy))
            else stop_with_error($sformatf("busy and result_last did not fall together in %s",
                                           cur_test));
            if (result_valid) begin
                check_result();
            end else begin
                assert (!result_last)
                else stop_with_error($sformatf("result_last without result_valid in %s",
                                               cur_test));
            end
            busy_q = busy;
        end
    end

    initial begin
        int nl;
        int nfv;
        reset      = 1'b1;
        fire       = 1'b0;
        num_layers = '0;
        num_fv     = FV_CNT_W'(4);
        wload_en   = 1'b0;
        wload_addr = '0;
        wload_data = '0;
        fload_en   = 1'b0;
        fload_addr = '0;
        fload_data = '0;
        fired_once = 1'b0;
        cur_test   = "reset";
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) next_cycle();

        load_data(RAND_VAL, RAND_VAL);
        run_layers("single_layer", 0, 4, 1'b0);

        for (int r = 0; r < 12; r++) begin
            nl  = int'(rand_bits(2));
            nfv = 4 * (int'(rand_bits(2)) + 1);
            load_data(RAND_VAL, RAND_VAL);
            run_layers("multi_layer", nl, nfv, 1'b0);
        end

        // largest positive and negative sums, then a random mix of limits
        load_data(MIN_VAL, MIN_VAL);
        run_layers("extreme_min_min", 3, 16, 1'b0);
        load_data(MAX_VAL, MIN_VAL);
        run_layers("extreme_max_min", 3, 16, 1'b0);
        load_data(RAND_EXTREME, RAND_EXTREME);
        run_layers("extreme_mixed", 3, 16, 1'b0);

        load_data(RAND_VAL, RAND_VAL);
        run_layers("fire_while_busy", 3, 8, 1'b1);
        run_layers("fire_while_busy_short", 0, 4, 1'b1);
        // a wrongly taken fire would show up as a stray result here
        repeat (40) next_cycle();

        load_data(RAND_VAL, RAND_VAL);
        run_layers("reload_first", 3, 16, 1'b0);
        load_data(RAND_VAL, RAND_VAL);
        run_layers("reload_second", 3, 16, 1'b0);
        load_data(RAND_VAL, RAND_VAL);
        run_layers("reload_shorter", 1, 12, 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- vertex_update_top.sv
module vertex_update_top
    import gnn_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fire,
    input  logic [LAYER_W-1:0]        num_layers,
    input  logic [FV_CNT_W-1:0]       num_fv,
    input  logic                      wload_en,
    input  logic [WADDR_W-1:0]        wload_addr,
    input  logic [WEIGHT_SRAM_BW-1:0] wload_data,
    input  logic                      fload_en,
    input  logic [CHUNK_W-1:0]        fload_addr,
    input  logic [WEIGHT_SRAM_BW-1:0] fload_data,
    output logic                      busy,
    output logic                      result_valid,
    output logic signed [ACC_W-1:0]   result_data,
    output logic [LAYER_W-1:0]        result_layer,
    output logic                      result_last
);

    weight_stream_if ws_if ();

    logic      feat_valid;
    lane_vec_t feat_lanes;

    weight_cntl weight_cntl_inst (
        .clk        (clk),
        .reset      (reset),
        .fire       (fire),
        .num_layers (num_layers),
        .num_fv     (num_fv),
        .wload_en   (wload_en),
        .wload_addr (wload_addr),
        .wload_data (wload_data),
        .busy       (busy),
        .ws         (ws_if.src)
    );

    feature_streamer feature_streamer_inst (
        .clk        (clk),
        .reset      (reset),
        .fire       (fire),
        .num_layers (num_layers),
        .num_fv     (num_fv),
        .fload_en   (fload_en),
        .fload_addr (fload_addr),
        .fload_data (fload_data),
        .feat_valid (feat_valid),
        .feat_lanes (feat_lanes)
    );

    vertex_mac vertex_mac_inst (
        .clk          (clk),
        .reset        (reset),
        .ws           (ws_if.snk),
        .feat_valid   (feat_valid),
        .feat_lanes   (feat_lanes),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_layer (result_layer),
        .result_last  (result_last)
    );

endmodule

//--- vertex_mac.sv
module vertex_mac
    import gnn_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    weight_stream_if.snk              ws,
    input  logic                      feat_valid,
    input  lane_vec_t                 feat_lanes,
    output logic                      result_valid,
    output logic signed [ACC_W-1:0]   result_data,
    output logic [LAYER_W-1:0]        result_layer,
    output logic                      result_last
);

    logic signed [PROD_W-1:0] prod     [MULT_PER_PE];
    logic signed [PROD_W:0]   pair_sum [MULT_PER_PE/2];
    logic signed [ACC_W-1:0]  tree_sum;
    logic signed [ACC_W-1:0]  beat_sum;
    logic signed [ACC_W-1:0]  base;
    logic signed [ACC_W-1:0]  total;
    logic signed [ACC_W-1:0]  acc;
    logic [LAYER_W-1:0]       layer_cnt;
    logic [LAYER_W-1:0]       cur_layer;
    logic                     last_beat;

    // lane products, then pairs, then the final add
    always_comb begin
        for (int i = 0; i < MULT_PER_PE; i++) begin
            prod[i] = ws.lanes[i] * feat_lanes[i];
        end
        for (int i = 0; i < MULT_PER_PE / 2; i++) begin
            pair_sum[i] = prod[2*i] + prod[2*i+1];
        end
        tree_sum = '0;
        for (int i = 0; i < MULT_PER_PE / 2; i++) begin
            tree_sum = tree_sum + pair_sum[i];
        end
    end

    // streams are aligned upstream, feat_valid only gates the sum
    assign beat_sum = feat_valid ? tree_sum : '0;

    // first beat of every layer starts from zero
    assign base      = (ws.sos || ws.cur_fv_num == '0) ? '0 : acc;
    assign total     = base + beat_sum;
    assign cur_layer = ws.sos ? '0 : layer_cnt;
    assign last_beat = ws.valid && ws.change;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result_last  <= 1'b0;
            layer_cnt    <= '0;
        end else begin
            result_valid <= last_beat;
            result_last  <= ws.valid && ws.eos;
            if (last_beat) begin
                layer_cnt <= cur_layer + 1'b1;
            end else if (ws.valid) begin
                layer_cnt <= cur_layer;
            end
        end
    end

    // running sum and the per-layer result
    always_ff @(posedge clk) begin
        if (ws.valid) begin
            acc <= total;
        end
        if (last_beat) begin
            result_data  <= total;
            result_layer <= cur_layer;
        end
    end

endmodule

//--- feature_streamer.sv
module feature_streamer
    import gnn_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fire,
    input  logic [LAYER_W-1:0]        num_layers,
    input  logic [FV_CNT_W-1:0]       num_fv,
    input  logic                      fload_en,
    input  logic [CHUNK_W-1:0]        fload_addr,
    input  logic [WEIGHT_SRAM_BW-1:0] fload_data,
    output logic                      feat_valid,
    output lane_vec_t                 feat_lanes
);

    lane_vec_t          feat_mem [NUM_CHUNKS];
    logic               run;
    logic [CHUNK_W-1:0] chunk;
    logic [LAYER_W-1:0] pass;
    logic [CHUNK_W-1:0] last_chunk;
    logic               active;
    logic               fire_ok;

    // pipe matched to address reg and sram read
    logic               v1, v2;
    lane_vec_t          d1, d2;

    assign last_chunk = last_chunk_of(num_fv);

    // idle once the last beat has gone out, same window as busy
    assign active  = run | v1 | v2 | feat_valid;
    assign fire_ok = fire & ~active;

    always_ff @(posedge clk) begin
        if (fload_en) begin
            feat_mem[fload_addr] <= lane_vec_t'(fload_data);
        end
    end

    // one pass over the chunks per layer
    always_ff @(posedge clk) begin
        if (reset) begin
            run   <= 1'b0;
            chunk <= '0;
            pass  <= '0;
        end else if (fire_ok) begin
            run   <= 1'b1;
            chunk <= '0;
            pass  <= '0;
        end else if (run) begin
            if (chunk == last_chunk) begin
                chunk <= '0;
                if (pass == num_layers) begin
                    run  <= 1'b0;
                    pass <= '0;
                end else begin
                    pass <= pass + 1'b1;
                end
            end else begin
                chunk <= chunk + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v1         <= 1'b0;
            v2         <= 1'b0;
            feat_valid <= 1'b0;
        end else begin
            v1         <= run;
            v2         <= v1;
            feat_valid <= v2;
        end
    end

    always_ff @(posedge clk) begin
        d1         <= feat_mem[chunk];
        d2         <= d1;
        feat_lanes <= d2;
    end

endmodule

//--- weight_cntl.sv
module weight_cntl
    import gnn_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fire,
    input  logic [LAYER_W-1:0]        num_layers,
    input  logic [FV_CNT_W-1:0]       num_fv,
    input  logic                      wload_en,
    input  logic [WADDR_W-1:0]        wload_addr,
    input  logic [WEIGHT_SRAM_BW-1:0] wload_data,
    output logic                      busy,
    weight_stream_if.src              ws
);

    typedef enum logic {
        IDLE,
        WORK
    } state_t;

    state_t               state;
    logic [CHUNK_W-1:0]   chunk;
    logic [LAYER_W-1:0]   layer;
    logic [CHUNK_W-1:0]   last_chunk;
    logic                 layer_end;
    logic                 run_end;
    logic                 fire_ok;

    // address stage, shared by loads and reads
    logic                      cen_q;
    logic                      wen_q;
    logic [WADDR_W-1:0]        a_q;
    logic [WEIGHT_SRAM_BW-1:0] d_q;
    logic                      rd1;
    logic                      sos1, chg1, eos1;
    logic [FV_IDX_W-1:0]       fv1;

    // stage in step with sram q
    logic                      rd2;
    logic                      sos2, chg2, eos2;
    logic [FV_IDX_W-1:0]       fv2;

    logic [WEIGHT_SRAM_BW-1:0] sram_q;

    assign last_chunk = last_chunk_of(num_fv);
    assign layer_end  = (chunk == last_chunk);
    assign run_end    = layer_end && (layer == num_layers);
    assign fire_ok    = fire && (state == IDLE) && !busy;

    // layer and chunk sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            chunk <= '0;
            layer <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fire_ok) begin
                        state <= WORK;
                        chunk <= '0;
                        layer <= '0;
                    end
                end
                WORK: begin
                    if (layer_end) begin
                        chunk <= '0;
                        if (run_end) begin
                            state <= IDLE;
                            layer <= '0;
                        end else begin
                            layer <= layer + 1'b1;
                        end
                    end else begin
                        chunk <= chunk + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // high from the cycle after fire until the eos beat has left
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (state == WORK) begin
            busy <= 1'b1;
        end else if (ws.eos) begin
            busy <= 1'b0;
        end
    end

    // read while working, load writes while idle
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_q <= 1'b1;
            wen_q <= 1'b1;
            rd1   <= 1'b0;
            sos1  <= 1'b0;
            chg1  <= 1'b0;
            eos1  <= 1'b0;
        end else if (state == WORK) begin
            cen_q <= 1'b0;
            wen_q <= 1'b1;
            rd1   <= 1'b1;
            sos1  <= (chunk == '0) && (layer == '0);
            chg1  <= layer_end;
            eos1  <= run_end;
        end else begin
            cen_q <= ~wload_en;
            wen_q <= ~wload_en;
            rd1   <= 1'b0;
            sos1  <= 1'b0;
            chg1  <= 1'b0;
            eos1  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        a_q <= (state == WORK) ? {layer, chunk} : wload_addr;
        d_q <= wload_data;
        fv1 <= FV_IDX_W'(chunk) << LANE_SH;
        fv2 <= fv1;
        ws.cur_fv_num <= fv2;
        ws.lanes      <= lane_vec_t'(sram_q);
    end

    // markers wait out the sram read, then leave with the lanes
    always_ff @(posedge clk) begin
        if (reset) begin
            rd2       <= 1'b0;
            sos2      <= 1'b0;
            chg2      <= 1'b0;
            eos2      <= 1'b0;
            ws.valid  <= 1'b0;
            ws.sos    <= 1'b0;
            ws.change <= 1'b0;
            ws.eos    <= 1'b0;
        end else begin
            rd2       <= rd1;
            sos2      <= sos1;
            chg2      <= chg1;
            eos2      <= eos1;
            ws.valid  <= rd2;
            ws.sos    <= sos2;
            ws.change <= chg2;
            ws.eos    <= eos2;
        end
    end

    weight_sram weight_sram_inst (
        .clk (clk),
        .cen (cen_q),
        .wen (wen_q),
        .a   (a_q),
        .d   (d_q),
        .q   (sram_q)
    );

endmodule

//--- weight_sram.sv
module weight_sram
    import gnn_pkg::*;
(
    input  logic                      clk,
    input  logic                      cen,
    input  logic                      wen,
    input  logic [WADDR_W-1:0]        a,
    input  logic [WEIGHT_SRAM_BW-1:0] d,
    output logic [WEIGHT_SRAM_BW-1:0] q
);

    logic [WEIGHT_SRAM_BW-1:0] mem [SRAM_DEPTH];

    // active-low enables, q holds until the next read
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[a] <= d;
            end else begin
                q <= mem[a];
            end
        end
    end

endmodule

//--- weight_stream_if.sv
interface weight_stream_if
    import gnn_pkg::*;
();

    logic                valid;
    lane_vec_t           lanes;
    logic [FV_IDX_W-1:0] cur_fv_num;
    // run and layer markers
    logic                sos;
    logic                change;
    logic                eos;

    modport src (
        output valid, lanes, cur_fv_num, sos, change, eos
    );

    modport snk (
        input valid, lanes, cur_fv_num, sos, change, eos
    );

endinterface

//--- gnn_pkg.sv
package gnn_pkg;

    // element and lane sizes
    localparam int FV_SIZE           = 16;
    localparam int MULT_PER_PE       = 4;
    localparam int MAX_FV_NUM        = 16;
    localparam int MAX_WEIGHT_LAYERS = 4;

    // one sram line holds one beat of lanes
    localparam int WEIGHT_SRAM_BW = MULT_PER_PE * FV_SIZE;

    localparam int NUM_CHUNKS = MAX_FV_NUM / MULT_PER_PE;
    localparam int CHUNK_W    = $clog2(NUM_CHUNKS);
    localparam int LAYER_W    = $clog2(MAX_WEIGHT_LAYERS);
    localparam int LANE_SH    = $clog2(MULT_PER_PE);

    // address is {layer, chunk}
    localparam int WADDR_W    = LAYER_W + CHUNK_W;
    localparam int SRAM_DEPTH = 1 << WADDR_W;

    // count holds 0..MAX_FV_NUM, index holds 0..MAX_FV_NUM-1
    localparam int FV_CNT_W = $clog2(MAX_FV_NUM) + 1;
    localparam int FV_IDX_W = $clog2(MAX_FV_NUM);

    // full product and room for MAX_FV_NUM of them
    localparam int PROD_W = 2 * FV_SIZE;
    localparam int ACC_W  = PROD_W + $clog2(MAX_FV_NUM);

    typedef logic signed [FV_SIZE-1:0] elem_t;

    // lane i sits in bits 16i+15:16i of a line
    typedef elem_t [MULT_PER_PE-1:0] lane_vec_t;

    // index of the last chunk for a given vector length
    function automatic logic [CHUNK_W-1:0] last_chunk_of(input logic [FV_CNT_W-1:0] num_fv);
        logic [FV_CNT_W-1:0] chunks;
        chunks = (num_fv >> LANE_SH) - 1'b1;
        return chunks[CHUNK_W-1:0];
    endfunction

endpackage
